//--- design/video_pkg.sv
package video_pkg;

    // Default frame size of the camera image on the tracking path
    localparam int HRES_DEFAULT = 320;
    localparam int VRES_DEFAULT = 180;

    // Pixel coordinate widths, wide enough for a full 720p raster
    localparam int HCOUNT_W = 11;
    localparam int VCOUNT_W = 10;

    // Field widths inside one RGB565 camera word
    localparam int RED_W   = 5;
    localparam int GREEN_W = 6;
    localparam int BLUE_W  = 5;

    localparam int CHANNEL_W = 8; // Expanded color channel and luma

    typedef logic [HCOUNT_W-1:0] hcount_t;
    typedef logic [VCOUNT_W-1:0] vcount_t;

    // Red in the top bits, blue in the bottom bits
    typedef logic [RED_W+GREEN_W+BLUE_W-1:0] rgb565_t;

    typedef logic [CHANNEL_W-1:0] channel_t;

endpackage

//--- design/track_pkg.sv
package track_pkg;

    // Luma approximation (2R + 5G + B) / 8, cheap in adders
    localparam int LUMA_R_WEIGHT = 2;
    localparam int LUMA_G_WEIGHT = 5;
    localparam int LUMA_B_WEIGHT = 1;
    localparam int LUMA_SHIFT    = 3;

    // Per-frame coordinate sums
    localparam int SUM_W = 32;

    // Masked pixel count, covers a full 320x180 frame with margin
    localparam int COUNT_W = 20;

    typedef logic [COUNT_W-1:0] count_t;

    // Crosshair drawn over the centroid, packed as {red, green, blue}
    localparam logic [23:0] CROSSHAIR_COLOR = 24'h00_FF_00;

endpackage

//--- design/pixel_decode.sv
module pixel_decode (
    input  logic                clk_pixel,
    input  logic                recent_reset,
    input  logic                pixel_valid_i,
    input  video_pkg::rgb565_t  pixel_data_i,
    input  video_pkg::hcount_t  hcount_i,
    input  video_pkg::vcount_t  vcount_i,
    output logic                dec_valid_o,
    output video_pkg::channel_t red_o,
    output video_pkg::channel_t green_o,
    output video_pkg::channel_t blue_o,
    output video_pkg::channel_t luma_o,
    output video_pkg::hcount_t  hcount_o,
    output video_pkg::vcount_t  vcount_o
);

    localparam int RED_W      = video_pkg::RED_W;
    localparam int GREEN_W    = video_pkg::GREEN_W;
    localparam int BLUE_W     = video_pkg::BLUE_W;
    localparam int CHANNEL_W  = video_pkg::CHANNEL_W;
    localparam int LUMA_SUM_W = 12; // Largest weighted sum is 2004

    video_pkg::channel_t   red_x;
    video_pkg::channel_t   green_x;
    video_pkg::channel_t   blue_x;
    logic [LUMA_SUM_W-1:0] luma_sum;

    always_comb begin
        // Low bits padded with zeros, as on the display side
        red_x   = video_pkg::channel_t'(pixel_data_i[RED_W+GREEN_W+BLUE_W-1 -: RED_W])
                  << (CHANNEL_W - RED_W);
        green_x = video_pkg::channel_t'(pixel_data_i[GREEN_W+BLUE_W-1 -: GREEN_W])
                  << (CHANNEL_W - GREEN_W);
        blue_x  = video_pkg::channel_t'(pixel_data_i[BLUE_W-1:0]) << (CHANNEL_W - BLUE_W);
        luma_sum = LUMA_SUM_W'(track_pkg::LUMA_R_WEIGHT * red_x
                             + track_pkg::LUMA_G_WEIGHT * green_x
                             + track_pkg::LUMA_B_WEIGHT * blue_x);
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= pixel_valid_i;
        end
    end

    always_ff @(posedge clk_pixel) begin
        red_o    <= red_x;
        green_o  <= green_x;
        blue_o   <= blue_x;
        luma_o   <= video_pkg::channel_t'(luma_sum >> track_pkg::LUMA_SHIFT);
        hcount_o <= hcount_i;
        vcount_o <= vcount_i;
    end

endmodule

//--- design/centroid_divider.sv
module centroid_divider (
    input  logic                       clk_pixel,
    input  logic                       recent_reset,
    input  logic                       start_i,
    input  logic [track_pkg::SUM_W-1:0] dividend_i,
    input  track_pkg::count_t          divisor_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic [track_pkg::SUM_W-1:0] quotient_o
);

    localparam int SUM_W   = track_pkg::SUM_W;
    localparam int COUNT_W = track_pkg::COUNT_W;
    localparam int STEP_W  = $clog2(SUM_W + 1);

    logic [STEP_W-1:0]  steps_left;  // Quotient bits still to resolve
    logic [COUNT_W-1:0] rem_q;       // Partial remainder, always below the divisor
    logic [SUM_W-1:0]   quot_q;      // Dividend shifts out as quotient shifts in
    track_pkg::count_t  divisor_q;
    logic [COUNT_W:0]   trial;
    logic [COUNT_W:0]   diff;
    logic               fits;
    logic               load;

    assign load = start_i && !busy_o;

    always_comb begin
        trial = {rem_q, quot_q[SUM_W-1]};
        diff  = trial - {1'b0, divisor_q};
        fits  = trial >= {1'b0, divisor_q};
    end

    // One step per quotient bit, then one more cycle for done
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            busy_o     <= 1'b0;
            done_o     <= 1'b0;
            steps_left <= '0;
        end else begin
            done_o <= 1'b0;
            if (load) begin
                busy_o     <= 1'b1;
                steps_left <= STEP_W'(SUM_W);
            end else if (busy_o) begin
                if (steps_left == '0) begin
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    steps_left <= steps_left - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (load) begin
            rem_q     <= '0;
            quot_q    <= dividend_i;
            divisor_q <= divisor_i;
        end else if (busy_o && steps_left != '0) begin
            rem_q  <= fits ? diff[COUNT_W-1:0] : trial[COUNT_W-1:0]; // Restore on miss
            quot_q <= {quot_q[SUM_W-2:0], fits};
        end
    end

    assign quotient_o = quot_q;

endmodule

//--- design/blob_centroid.sv
module blob_centroid #(
    parameter int HRES = video_pkg::HRES_DEFAULT,
    parameter int VRES = video_pkg::VRES_DEFAULT
) (
    input  logic                clk_pixel,
    input  logic                recent_reset,
    input  logic                dec_valid_i,
    input  video_pkg::channel_t luma_i,
    input  video_pkg::hcount_t  hcount_i,
    input  video_pkg::vcount_t  vcount_i,
    input  video_pkg::channel_t lower_threshold_i,
    input  video_pkg::channel_t upper_threshold_i,
    output logic                mask_o,
    output logic                centroid_valid_o,
    output video_pkg::hcount_t  centroid_x_o,
    output video_pkg::vcount_t  centroid_y_o,
    output logic                have_centroid_o
);

    localparam int SUM_W = track_pkg::SUM_W;
    localparam video_pkg::hcount_t LAST_H = video_pkg::hcount_t'(HRES - 1);
    localparam video_pkg::vcount_t LAST_V = video_pkg::vcount_t'(VRES - 1);

    logic [SUM_W-1:0]  sum_x, sum_y;
    logic [SUM_W-1:0]  sum_x_next, sum_y_next;
    track_pkg::count_t pix_count, count_next;
    logic [SUM_W-1:0]  total_x, total_y; // Frame totals handed to the dividers
    track_pkg::count_t total_n;
    logic              hit;
    logic              frame_end;
    logic              div_idle;
    logic              div_start;
    logic              busy_x, busy_y;
    logic              done_x, done_y;
    logic              both_done;        // Both dividers run the same number of steps
    logic [SUM_W-1:0]  quot_x, quot_y;

    assign mask_o    = (luma_i > lower_threshold_i) && (luma_i <= upper_threshold_i);
    assign hit       = dec_valid_i && mask_o;
    assign frame_end = dec_valid_i && (hcount_i == LAST_H) && (vcount_i == LAST_V);
    assign div_idle  = !div_start && !busy_x && !busy_y;
    assign both_done = done_x && done_y;

    // The last pixel of the frame still counts
    always_comb begin
        sum_x_next = sum_x + (hit ? SUM_W'(hcount_i) : '0);
        sum_y_next = sum_y + (hit ? SUM_W'(vcount_i) : '0);
        count_next = pix_count + track_pkg::count_t'(hit);
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            sum_x     <= '0;
            sum_y     <= '0;
            pix_count <= '0;
            div_start <= 1'b0;
        end else begin
            div_start <= 1'b0;
            if (frame_end) begin
                sum_x     <= '0;
                sum_y     <= '0;
                pix_count <= '0;
                div_start <= (count_next != '0) && div_idle; // Empty frame keeps old centroid
            end else if (hit) begin
                sum_x     <= sum_x_next;
                sum_y     <= sum_y_next;
                pix_count <= count_next;
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (frame_end && div_idle) begin
            total_x <= sum_x_next;
            total_y <= sum_y_next;
            total_n <= count_next;
        end
    end

    centroid_divider div_x (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .start_i      (div_start),
        .dividend_i   (total_x),
        .divisor_i    (total_n),
        .busy_o       (busy_x),
        .done_o       (done_x),
        .quotient_o   (quot_x)
    );

    centroid_divider div_y (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .start_i      (div_start),
        .dividend_i   (total_y),
        .divisor_i    (total_n),
        .busy_o       (busy_y),
        .done_o       (done_y),
        .quotient_o   (quot_y)
    );

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            centroid_valid_o <= 1'b0;
            have_centroid_o  <= 1'b0;
        end else begin
            centroid_valid_o <= both_done;
            if (both_done) begin
                have_centroid_o <= 1'b1;
            end
        end
    end

    // Mean of a coordinate never exceeds the coordinate range
    always_ff @(posedge clk_pixel) begin
        if (both_done) begin
            centroid_x_o <= video_pkg::hcount_t'(quot_x);
            centroid_y_o <= video_pkg::vcount_t'(quot_y);
        end
    end

endmodule

//--- design/overlay_compose.sv
module overlay_compose (
    input  logic                clk_pixel,
    input  logic                recent_reset,
    input  logic                dec_valid_i,
    input  video_pkg::channel_t red_i,
    input  video_pkg::channel_t green_i,
    input  video_pkg::channel_t blue_i,
    input  video_pkg::hcount_t  hcount_i,
    input  video_pkg::vcount_t  vcount_i,
    input  logic                mask_i,
    input  logic                mask_view_i,
    input  logic                have_centroid_i,
    input  video_pkg::hcount_t  centroid_x_i,
    input  video_pkg::vcount_t  centroid_y_i,
    output logic                pixel_valid_o,
    output video_pkg::channel_t red_o,
    output video_pkg::channel_t green_o,
    output video_pkg::channel_t blue_o
);

    localparam int RGB_W = 3 * video_pkg::CHANNEL_W;

    logic             on_cross;
    logic [RGB_W-1:0] color_next; // Packed as {red, green, blue}

    always_comb begin
        on_cross = have_centroid_i
                   && ((hcount_i == centroid_x_i) || (vcount_i == centroid_y_i));
        if (on_cross) begin
            color_next = track_pkg::CROSSHAIR_COLOR;
        end else if (mask_view_i) begin
            color_next = mask_i ? '1 : '0; // White blob on black
        end else begin
            color_next = {red_i, green_i, blue_i};
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            pixel_valid_o <= 1'b0;
        end else begin
            pixel_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_pixel) begin
        {red_o, green_o, blue_o} <= color_next;
    end

endmodule

//--- design/juggle_tracker_top.sv
module juggle_tracker_top #(
    parameter int HRES = video_pkg::HRES_DEFAULT,
    parameter int VRES = video_pkg::VRES_DEFAULT
) (
    input  logic                clk_pixel,
    input  logic                recent_reset,
    input  logic                pixel_valid_i,
    input  video_pkg::rgb565_t  pixel_data_i,
    input  video_pkg::hcount_t  pixel_hcount_i,
    input  video_pkg::vcount_t  pixel_vcount_i,
    input  video_pkg::channel_t lower_threshold_i,
    input  video_pkg::channel_t upper_threshold_i,
    input  logic                mask_view_i,
    output logic                pixel_valid_o,
    output video_pkg::channel_t red_o,
    output video_pkg::channel_t green_o,
    output video_pkg::channel_t blue_o,
    output logic                centroid_valid_o,
    output video_pkg::hcount_t  centroid_x_o,
    output video_pkg::vcount_t  centroid_y_o
);

    logic                dec_valid;
    video_pkg::channel_t dec_red;
    video_pkg::channel_t dec_green;
    video_pkg::channel_t dec_blue;
    video_pkg::channel_t dec_luma;
    video_pkg::hcount_t  dec_hcount;
    video_pkg::vcount_t  dec_vcount;
    logic                mask;          // Combinational, lines up with the decoded pixel
    logic                have_centroid;

    pixel_decode u_decode (
        .clk_pixel     (clk_pixel),
        .recent_reset  (recent_reset),
        .pixel_valid_i (pixel_valid_i),
        .pixel_data_i  (pixel_data_i),
        .hcount_i      (pixel_hcount_i),
        .vcount_i      (pixel_vcount_i),
        .dec_valid_o   (dec_valid),
        .red_o         (dec_red),
        .green_o       (dec_green),
        .blue_o        (dec_blue),
        .luma_o        (dec_luma),
        .hcount_o      (dec_hcount),
        .vcount_o      (dec_vcount)
    );

    blob_centroid #(
        .HRES (HRES),
        .VRES (VRES)
    ) u_centroid (
        .clk_pixel         (clk_pixel),
        .recent_reset      (recent_reset),
        .dec_valid_i       (dec_valid),
        .luma_i            (dec_luma),
        .hcount_i          (dec_hcount),
        .vcount_i          (dec_vcount),
        .lower_threshold_i (lower_threshold_i),
        .upper_threshold_i (upper_threshold_i),
        .mask_o            (mask),
        .centroid_valid_o  (centroid_valid_o),
        .centroid_x_o      (centroid_x_o),
        .centroid_y_o      (centroid_y_o),
        .have_centroid_o   (have_centroid)
    );

    overlay_compose u_compose (
        .clk_pixel       (clk_pixel),
        .recent_reset    (recent_reset),
        .dec_valid_i     (dec_valid),
        .red_i           (dec_red),
        .green_i         (dec_green),
        .blue_i          (dec_blue),
        .hcount_i        (dec_hcount),
        .vcount_i        (dec_vcount),
        .mask_i          (mask),
        .mask_view_i     (mask_view_i),
        .have_centroid_i (have_centroid),
        .centroid_x_i    (centroid_x_o),
        .centroid_y_i    (centroid_y_o),
        .pixel_valid_o   (pixel_valid_o),
        .red_o           (red_o),
        .green_o         (green_o),
        .blue_o          (blue_o)
    );

endmodule

//--- tb/tracker_checker.sv
module tracker_checker (
    input  logic                clk_pixel,
    input  logic                recent_reset,
    input  logic                pixel_valid_i,
    input  video_pkg::rgb565_t  pixel_data_i,
    input  video_pkg::hcount_t  pixel_hcount_i,
    input  video_pkg::vcount_t  pixel_vcount_i,
    input  video_pkg::channel_t lower_threshold_i,
    input  video_pkg::channel_t upper_threshold_i,
    input  logic                mask_view_i,
    input  logic                out_valid_i,
    input  video_pkg::channel_t red_i,
    input  video_pkg::channel_t green_i,
    input  video_pkg::channel_t blue_i,
    input  logic                centroid_valid_i,
    input  video_pkg::hcount_t  centroid_x_i,
    input  video_pkg::vcount_t  centroid_y_i,
    input  logic                have_centroid_i
);

    localparam logic [23:0] WHITE = 24'hFF_FF_FF;
    localparam logic [23:0] BLACK = 24'h00_00_00;

    int                  fail_count = 0;
    logic                rst_d1;
    logic                valid_d1, valid_d2;
    video_pkg::rgb565_t  data_d1, data_d2;
    video_pkg::hcount_t  h_d1;
    video_pkg::vcount_t  v_d1;
    logic                view_d1;    // Mask view as seen by the compose stage
    video_pkg::channel_t lower_d1, upper_d1;
    logic                seen_pulse; // A centroid has been published since reset
    logic                cross_d1;   // Pixel lies on the crosshair when composed
    int                  luma_sum;
    video_pkg::channel_t luma_exp;
    logic                in_window;
    logic [23:0]         rgb_exp;
    logic [23:0]         rgb_out;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            seen_pulse <= 1'b0;
        end else if (centroid_valid_i) begin
            seen_pulse <= 1'b1;
        end
    end

    // Input history, lined up with the compose register
    always_ff @(posedge clk_pixel) begin
        rst_d1   <= recent_reset;
        valid_d1 <= pixel_valid_i;
        valid_d2 <= valid_d1;
        data_d1  <= pixel_data_i;
        data_d2  <= data_d1;
        h_d1     <= pixel_hcount_i;
        v_d1     <= pixel_vcount_i;
        view_d1  <= mask_view_i;
        lower_d1 <= lower_threshold_i;
        upper_d1 <= upper_threshold_i;
        cross_d1 <= (seen_pulse || centroid_valid_i)
                    && (h_d1 == centroid_x_i || v_d1 == centroid_y_i);
    end

    always_comb begin
        rgb_exp   = {data_d2[15:11], 3'b000, data_d2[10:5], 2'b00, data_d2[4:0], 3'b000};
        luma_sum  = track_pkg::LUMA_R_WEIGHT * int'(rgb_exp[23:16])
                  + track_pkg::LUMA_G_WEIGHT * int'(rgb_exp[15:8])
                  + track_pkg::LUMA_B_WEIGHT * int'(rgb_exp[7:0]);
        luma_exp  = video_pkg::channel_t'(luma_sum >> track_pkg::LUMA_SHIFT);
        in_window = (luma_exp > lower_d1) && (luma_exp <= upper_d1);
    end

    assign rgb_out = {red_i, green_i, blue_i};

    a_reset_state: assert property (@(posedge clk_pixel)
        recent_reset |=> !out_valid_i && !centroid_valid_i && !have_centroid_i)
    else begin
        fail_count++;
        $error("CHECK FAILED t=%0t %s expected 000 actual %b%b%b",
               $time, "pixel_valid_o/centroid_valid_o/have_centroid",
               $sampled(out_valid_i), $sampled(centroid_valid_i), $sampled(have_centroid_i));
    end

    a_valid_latency: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        !rst_d1 |-> out_valid_i == valid_d2)
    else begin
        fail_count++;
        $error("CHECK FAILED t=%0t pixel_valid_o expected %b actual %b",
               $time, $sampled(valid_d2), $sampled(out_valid_i));
    end

    a_camera_color: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        !rst_d1 && valid_d2 && !view_d1 && !cross_d1 |-> rgb_out == rgb_exp)
    else begin
        fail_count++;
        $error("CHECK FAILED t=%0t rgb_o expected %h actual %h",
               $time, $sampled(rgb_exp), $sampled(rgb_out));
    end

    a_mask_view: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        !rst_d1 && valid_d2 && view_d1 && !cross_d1 |-> rgb_out == (in_window ? WHITE : BLACK))
    else begin
        fail_count++;
        $error("CHECK FAILED t=%0t rgb_o (mask view) expected %h actual %h",
               $time, $sampled(in_window) ? WHITE : BLACK, $sampled(rgb_out));
    end

    a_crosshair: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        !rst_d1 && valid_d2 && cross_d1 |-> rgb_out == track_pkg::CROSSHAIR_COLOR)
    else begin
        fail_count++;
        $error("CHECK FAILED t=%0t rgb_o (crosshair) expected %h actual %h",
               $time, track_pkg::CROSSHAIR_COLOR, $sampled(rgb_out));
    end

endmodule

//--- tb/tracker_tb.sv
module tracker_tb;

    localparam int HRES           = 16;
    localparam int VRES           = 12;
    localparam int NUM_FRAMES     = 4;
    localparam int FRAME_CYCLES   = 2 * HRES * VRES; // Each pixel plus at most one gap
    localparam int TIMEOUT_CYCLES = 2 * NUM_FRAMES * FRAME_CYCLES + 200;
    localparam video_pkg::channel_t LOWER = 8'd150;
    localparam video_pkg::channel_t UPPER = 8'd247; // Cuts off part of the bright block

    logic                clk_pixel;
    logic                recent_reset;
    logic                pixel_valid_i;
    video_pkg::rgb565_t  pixel_data_i;
    video_pkg::hcount_t  pixel_hcount_i;
    video_pkg::vcount_t  pixel_vcount_i;
    video_pkg::channel_t lower_threshold_i;
    video_pkg::channel_t upper_threshold_i;
    logic                mask_view_i;
    logic                pixel_valid_o;
    video_pkg::channel_t red_o, green_o, blue_o;
    logic                centroid_valid_o;
    video_pkg::hcount_t  centroid_x_o;
    video_pkg::vcount_t  centroid_y_o;

    int                 error_count     = 0;
    int                 cycle_count     = 0;
    int                 pulses_expected = 0;
    int                 pulses_seen     = 0;
    int                 total_errors;
    int                 exp_x           = 0;
    int                 exp_y           = 0;
    logic               seen_centroid   = 1'b0;
    video_pkg::hcount_t held_x;         // Centroid published by the last pulse
    video_pkg::vcount_t held_y;

    juggle_tracker_top #(
        .HRES (HRES),
        .VRES (VRES)
    ) dut (
        .clk_pixel         (clk_pixel),
        .recent_reset      (recent_reset),
        .pixel_valid_i     (pixel_valid_i),
        .pixel_data_i      (pixel_data_i),
        .pixel_hcount_i    (pixel_hcount_i),
        .pixel_vcount_i    (pixel_vcount_i),
        .lower_threshold_i (lower_threshold_i),
        .upper_threshold_i (upper_threshold_i),
        .mask_view_i       (mask_view_i),
        .pixel_valid_o     (pixel_valid_o),
        .red_o             (red_o),
        .green_o           (green_o),
        .blue_o            (blue_o),
        .centroid_valid_o  (centroid_valid_o),
        .centroid_x_o      (centroid_x_o),
        .centroid_y_o      (centroid_y_o)
    );

    bind juggle_tracker_top tracker_checker u_checker (
        .clk_pixel         (clk_pixel),
        .recent_reset      (recent_reset),
        .pixel_valid_i     (pixel_valid_i),
        .pixel_data_i      (pixel_data_i),
        .pixel_hcount_i    (pixel_hcount_i),
        .pixel_vcount_i    (pixel_vcount_i),
        .lower_threshold_i (lower_threshold_i),
        .upper_threshold_i (upper_threshold_i),
        .mask_view_i       (mask_view_i),
        .out_valid_i       (pixel_valid_o),
        .red_i             (red_o),
        .green_i           (green_o),
        .blue_i            (blue_o),
        .centroid_valid_i  (centroid_valid_o),
        .centroid_x_i      (centroid_x_o),
        .centroid_y_i      (centroid_y_o),
        .have_centroid_i   (have_centroid)
    );

    always #50 clk_pixel = ~clk_pixel;

    always @(posedge clk_pixel) begin
        cycle_count = cycle_count + 1;
        if (centroid_valid_o) begin
            pulses_seen   <= pulses_seen + 1;
            seen_centroid <= 1'b1;
            held_x        <= centroid_x_o;
            held_y        <= centroid_y_o;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles, %0d of %0d centroids seen",
                     cycle_count, pulses_seen, pulses_expected);
            $display("Regression failed");
            $finish;
        end
    end

    a_centroid_x: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        centroid_valid_o |-> centroid_x_o == exp_x)
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t centroid_x_o expected %0d actual %0d",
               $time, exp_x, $sampled(centroid_x_o));
    end

    a_centroid_y: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        centroid_valid_o |-> centroid_y_o == exp_y)
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t centroid_y_o expected %0d actual %0d",
               $time, exp_y, $sampled(centroid_y_o));
    end

    // A pulse needs a frame with masked pixels still waiting for its result
    a_pulse_owed: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        centroid_valid_o |-> pulses_seen < pulses_expected)
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t centroid_valid_o expected 0 actual 1", $time);
    end

    a_centroid_hold: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        seen_centroid && !centroid_valid_o |-> centroid_x_o == held_x && centroid_y_o == held_y)
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t centroid_x_o/centroid_y_o expected (%0d,%0d) actual (%0d,%0d)",
               $time, $sampled(held_x), $sampled(held_y),
               $sampled(centroid_x_o), $sampled(centroid_y_o));
    end

    function automatic int luma_of(input video_pkg::rgb565_t px);
        int r;
        int g;
        int b;
        r = int'(px[15:11]) << 3;
        g = int'(px[10:5]) << 2;
        b = int'(px[4:0]) << 3;
        return (track_pkg::LUMA_R_WEIGHT * r + track_pkg::LUMA_G_WEIGHT * g
                + track_pkg::LUMA_B_WEIGHT * b) >> track_pkg::LUMA_SHIFT;
    endfunction

    task automatic drive_pixel(input logic valid, input video_pkg::rgb565_t data,
                               input int h, input int v, input logic view);
        @(posedge clk_pixel);
        #10;
        pixel_valid_i  = valid;
        pixel_data_i   = data;
        pixel_hcount_i = video_pkg::hcount_t'(h);
        pixel_vcount_i = video_pkg::vcount_t'(v);
        mask_view_i    = view;
    endtask

    // View mode 0 is camera, 1 is mask, 2 picks one per pixel
    task automatic run_frame(input int x0, input int y0, input int w, input int h,
                             input int view_mode);
        int                 sum_x;
        int                 sum_y;
        int                 count;
        int                 luma;
        logic               view;
        video_pkg::rgb565_t px;
        sum_x = 0;
        sum_y = 0;
        count = 0;
        for (int v = 0; v < VRES; v++) begin
            for (int hh = 0; hh < HRES; hh++) begin
                view = (view_mode == 2) ? 1'($urandom % 2) : (view_mode == 1);
                if ($urandom % 4 == 0) begin
                    drive_pixel(1'b0, 16'hFFFF, HRES - 1, VRES - 1, view); // Idle gap
                end
                if (hh >= x0 && hh < x0 + w && v >= y0 && v < y0 + h) begin
                    px = 16'hFFFF ^ (video_pkg::rgb565_t'($urandom) & 16'h0841);
                end else begin
                    px = video_pkg::rgb565_t'($urandom) & 16'h38E7; // Dark background
                end
                drive_pixel(1'b1, px, hh, v, view);
                luma = luma_of(px);
                if (luma > LOWER && luma <= UPPER) begin
                    sum_x += hh;
                    sum_y += v;
                    count++;
                end
            end
        end
        if (count > 0) begin
            exp_x = sum_x / count;
            exp_y = sum_y / count;
            pulses_expected++;
        end
    endtask

    initial begin
        clk_pixel         = 1'b0;
        recent_reset      = 1'b1;
        pixel_valid_i     = 1'b0;
        pixel_data_i      = '0;
        pixel_hcount_i    = '0;
        pixel_vcount_i    = '0;
        lower_threshold_i = LOWER;
        upper_threshold_i = UPPER;
        mask_view_i       = 1'b0;
        void'($urandom(32'h6445));
        repeat (5) @(posedge clk_pixel);
        #10;
        recent_reset = 1'b0;
        drive_pixel(1'b0, '0, 0, 0, 1'b0);
        run_frame(3, 2, 4, 3, 0);
        run_frame(9, 6, 5, 4, 1);
        run_frame(0, 0, 0, 0, 0);  // Nothing in the window
        run_frame(1, 7, 6, 3, 2);
        drive_pixel(1'b0, '0, 0, 0, 1'b0);
        wait (pulses_seen == pulses_expected);
        repeat (4) @(posedge clk_pixel);
        total_errors = error_count + dut.u_checker.fail_count;
        $display("Errors: %0d (centroid %0d, pixel path %0d)",
                 total_errors, error_count, dut.u_checker.fail_count);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sources.f
design/video_pkg.sv
design/track_pkg.sv
design/pixel_decode.sv
design/centroid_divider.sv
design/blob_centroid.sv
design/overlay_compose.sv
design/juggle_tracker_top.sv
tb/tracker_checker.sv
tb/tracker_tb.sv

//--- Bender.yml
package:
  name: juggle_tracker

sources:
  - design/video_pkg.sv
  - design/track_pkg.sv
  - design/pixel_decode.sv
  - design/centroid_divider.sv
  - design/blob_centroid.sv
  - design/overlay_compose.sv
  - design/juggle_tracker_top.sv
  - target: test
    files:
      - tb/tracker_checker.sv
      - tb/tracker_tb.sv
